// File: hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int lsu_xlen      = 32;
  localparam int lsu_ram_words = 1024;
  localparam int lsu_word_aw   = 10;   // word index, address bits 11:2

  // funct3 codes of the RV32I loads and stores
  localparam logic [2:0] lsu_f3_b  = 3'b000;
  localparam logic [2:0] lsu_f3_h  = 3'b001;
  localparam logic [2:0] lsu_f3_w  = 3'b010;
  localparam logic [2:0] lsu_f3_bu = 3'b100;
  localparam logic [2:0] lsu_f3_hu = 3'b101;

  typedef enum logic [1:0] {
    lsu_op_none  = 2'd0,
    lsu_op_load  = 2'd1,
    lsu_op_store = 2'd2
  } lsu_op_e;

  // one request, strobed for a single cycle
  typedef struct packed {
    logic                valid;
    lsu_op_e             op;
    logic [2:0]          funct3;
    logic [lsu_xlen-1:0] src1;
    logic [lsu_xlen-1:0] src2;   // store data
    logic [lsu_xlen-1:0] imm;
  } lsu_req_t;

  typedef struct packed {
    logic                valid;
    logic                rd_wen;   // good load only
    logic                fault;
    logic [lsu_xlen-1:0] result;   // zero for stores and faults
  } lsu_resp_t;

  // one memory word, seen as bytes or as halfwords
  typedef union packed {
    logic [lsu_xlen/8-1:0][7:0]   b;
    logic [lsu_xlen/16-1:0][15:0] h;
  } lsu_word_u;

  // stage-1 record, between address generation and the RAM
  typedef struct packed {
    logic                   valid;
    logic                   is_load;
    logic                   is_store;
    logic                   fault;
    logic [lsu_word_aw-1:0] word_idx;
    logic [1:0]             offset;   // byte within the word
    logic [2:0]             funct3;
    logic [lsu_xlen/8-1:0]  wstrb;
    lsu_word_u              wdata;    // already steered into lanes
  } lsu_s1_t;

endpackage

`default_nettype wire

// File: hw/lsu_agu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  lsu_pkg::lsu_req_t req,
  output lsu_pkg::lsu_s1_t  s1
);

  logic [lsu_pkg::lsu_xlen-1:0]   addr;
  logic                           is_load;
  logic                           is_store;
  logic                           f3_ok;
  logic                           misaligned;
  logic [lsu_pkg::lsu_xlen/8-1:0] wstrb;
  lsu_pkg::lsu_word_u             wdata;
  lsu_pkg::lsu_s1_t               s1_next;

  assign addr     = req.src1 + req.imm;
  assign is_load  = req.valid && (req.op == lsu_pkg::lsu_op_load);
  assign is_store = req.valid && (req.op == lsu_pkg::lsu_op_store);

  // funct3 legality, unsigned variants exist for loads only
  always_comb begin
    case (req.funct3)
      lsu_pkg::lsu_f3_b,
      lsu_pkg::lsu_f3_h,
      lsu_pkg::lsu_f3_w:  f3_ok = 1'b1;
      lsu_pkg::lsu_f3_bu,
      lsu_pkg::lsu_f3_hu: f3_ok = is_load;
      default:            f3_ok = 1'b0;
    endcase
  end

  // funct3[1:0] is the access size
  always_comb begin
    case (req.funct3[1:0])
      2'b01:   misaligned = addr[0];
      2'b10:   misaligned = (addr[1:0] != 2'b00);
      default: misaligned = 1'b0;
    endcase
  end

  // lane steering for stores
  always_comb begin
    wdata = req.src2;
    wstrb = 4'b1111;
    case (req.funct3[1:0])
      2'b00: begin
        for (int i = 0; i < lsu_pkg::lsu_xlen / 8; i++) begin
          wdata.b[i] = req.src2[7:0];   // byte copied to every lane
        end
        wstrb = 4'b0001 << addr[1:0];
      end
      2'b01: begin
        for (int i = 0; i < lsu_pkg::lsu_xlen / 16; i++) begin
          wdata.h[i] = req.src2[15:0];
        end
        wstrb = 4'b0011 << addr[1:0];   // offset is even when legal
      end
      default: ;
    endcase
  end

  always_comb begin
    s1_next          = '0;
    s1_next.valid    = req.valid;
    s1_next.is_load  = is_load;
    s1_next.is_store = is_store;
    s1_next.fault    = (is_load || is_store) && (!f3_ok || misaligned);
    // bits above 11 drop out here, so the address wraps
    s1_next.word_idx = addr[lsu_pkg::lsu_word_aw+1:2];
    s1_next.offset   = addr[1:0];
    s1_next.funct3   = req.funct3;
    s1_next.wstrb    = is_store ? wstrb : 4'b0000;
    s1_next.wdata    = wdata;
  end

  always_ff @(posedge clk) begin
    s1 <= s1_next;
    if (!rst_n) begin
      s1.valid    <= 1'b0;
      s1.is_load  <= 1'b0;
      s1.is_store <= 1'b0;
      s1.fault    <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/lsu_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_data_ram (
  input  wire logic          clk,
  input  lsu_pkg::lsu_s1_t   s1,
  output lsu_pkg::lsu_word_u rdata
);

  logic [lsu_pkg::lsu_xlen/8-1:0][7:0] mem [lsu_pkg::lsu_ram_words];

  logic wr_en;
  logic rd_en;

  // faulted accesses never touch the array
  assign wr_en = s1.valid && s1.is_store && !s1.fault;
  assign rd_en = s1.valid && s1.is_load && !s1.fault;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < lsu_pkg::lsu_xlen / 8; i++) begin
        if (s1.wstrb[i]) begin
          mem[s1.word_idx][i] <= s1.wdata.b[i];
        end
      end
    end
  end

  // read-first, the word before this edge's write
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= mem[s1.word_idx];
    end
  end

endmodule

`default_nettype wire

// File: hw/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  lsu_pkg::lsu_s1_t   s1,
  input  lsu_pkg::lsu_word_u rdata,
  output lsu_pkg::lsu_resp_t resp
);

  // stage 2, lines up with the registered RAM word
  logic       s2_valid;
  logic       s2_load;
  logic       s2_fault;
  logic [1:0] s2_offset;
  logic [2:0] s2_funct3;

  logic [7:0]                   byte_sel;
  logic [15:0]                  half_sel;
  logic [lsu_pkg::lsu_xlen-1:0] load_val;
  logic                         good_load;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
      s2_load  <= 1'b0;
      s2_fault <= 1'b0;
    end else begin
      s2_valid <= s1.valid;
      s2_load  <= s1.is_load;
      s2_fault <= s1.fault;
    end
  end

  always_ff @(posedge clk) begin
    s2_offset <= s1.offset;
    s2_funct3 <= s1.funct3;
  end

  assign byte_sel = rdata.b[s2_offset];
  assign half_sel = rdata.h[s2_offset[1]];   // offset[0] is zero for legal halves

  // sign or zero extension by funct3
  always_comb begin
    case (s2_funct3)
      lsu_pkg::lsu_f3_b:  load_val = {{24{byte_sel[7]}}, byte_sel};
      lsu_pkg::lsu_f3_bu: load_val = {24'd0, byte_sel};
      lsu_pkg::lsu_f3_h:  load_val = {{16{half_sel[15]}}, half_sel};
      lsu_pkg::lsu_f3_hu: load_val = {16'd0, half_sel};
      lsu_pkg::lsu_f3_w:  load_val = rdata;
      default:            load_val = '0;
    endcase
  end

  assign good_load = s2_valid && s2_load && !s2_fault;

  always_comb begin
    resp        = '0;
    resp.valid  = s2_valid;
    resp.rd_wen = good_load;
    resp.fault  = s2_valid && s2_fault;
    resp.result = good_load ? load_val : '0;   // stores and faults give zero
  end

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  lsu_pkg::lsu_req_t  req,
  output lsu_pkg::lsu_resp_t resp
);

  lsu_pkg::lsu_s1_t   s1;      // address stage out, k+1
  lsu_pkg::lsu_word_u rdata;   // RAM word, k+2

  lsu_agu u_agu (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .s1    (s1)
  );

  lsu_data_ram u_ram (
    .clk   (clk),
    .s1    (s1),
    .rdata (rdata)
  );

  // response valid exactly two cycles after the request
  lsu_load_align u_align (
    .clk   (clk),
    .rst_n (rst_n),
    .s1    (s1),
    .rdata (rdata),
    .resp  (resp)
  );

endmodule

`default_nettype wire

// File: tests/lsu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  lsu_pkg::lsu_req_t  req,
  input  lsu_pkg::lsu_resp_t resp
);

  // fixed two-cycle pipeline, in both directions
  resp_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
      resp.valid == $past(req.valid, 2)
  ) else $error("resp.valid does not follow req.valid by exactly two cycles");

  wen_fault_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
      !(resp.rd_wen && resp.fault)
  ) else $error("rd_wen and fault high in the same cycle");

  reset_release_idle: assert property (
    @(posedge clk)
      $rose(rst_n) |-> !resp.valid
  ) else $error("resp.valid high in the cycle after reset release");

endmodule

`default_nettype wire

// File: tests/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  logic               clk = 1'b0;
  logic               rst_n;
  lsu_pkg::lsu_req_t  req;
  lsu_pkg::lsu_resp_t resp;

  logic [31:0] lfsr_state;
  int          cycle = 0;
  string       cur_test = "reset";

  lsu_pkg::lsu_word_u model_mem [64];   // word indices 0..63 only

  // expected responses, oldest first
  lsu_pkg::lsu_resp_t exp_q [$];
  int                 due_q [$];
  string              name_q [$];
  bit                 word_q [$];   // also a whole-word readback

  lsu_top u_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .resp  (resp)
  );

  bind lsu_top lsu_assertions u_assertions (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .resp  (resp)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_resp(input string name, input lsu_pkg::lsu_resp_t exp,
                            input lsu_pkg::lsu_resp_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s expected v=%b wen=%b f=%b r=%h actual v=%b wen=%b f=%b r=%h",
                         name, exp.valid, exp.rd_wen, exp.fault, exp.result,
                         act.valid, act.rd_wen, act.fault, act.result));
    end
  endtask

  task automatic check_word(input string name, input lsu_pkg::lsu_word_u exp,
                            input lsu_pkg::lsu_word_u act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s expected word %h actual word %h", name, exp, act));
    end
  endtask

  // target byte address split into src1 plus a small signed imm
  task automatic make_addr(input logic [5:0] widx, input logic [1:0] off, input bit wrap,
                           output logic [31:0] src1, output logic [31:0] imm);
    logic [31:0] r;
    logic [31:0] target;
    target = {24'd0, widx, off};
    rand_bits(5, r);
    imm  = {{27{r[4]}}, r[4:0]};
    src1 = target - imm;
    if (wrap) begin
      rand_bits(20, r);
      src1 = src1 + (r << 12);   // junk above bit 11
    end
  endtask

  // reference behavior, updates the model on a good store
  task automatic predict(input lsu_pkg::lsu_req_t r, output lsu_pkg::lsu_resp_t exp);
    logic [31:0] addr;
    logic [9:0]  idx;
    logic [1:0]  off;
    logic        legal;
    logic        aligned;
    logic [7:0]  bv;
    logic [15:0] hv;
    addr = r.src1 + r.imm;
    idx  = addr[11:2];
    off  = addr[1:0];
    exp  = '0;
    exp.valid = 1'b1;
    case (r.funct3)
      lsu_pkg::lsu_f3_h, lsu_pkg::lsu_f3_hu: aligned = !off[0];
      lsu_pkg::lsu_f3_w:                     aligned = (off == 2'd0);
      default:                               aligned = 1'b1;
    endcase
    if (r.op == lsu_pkg::lsu_op_load)
      legal = r.funct3 inside {lsu_pkg::lsu_f3_b, lsu_pkg::lsu_f3_h, lsu_pkg::lsu_f3_w,
                               lsu_pkg::lsu_f3_bu, lsu_pkg::lsu_f3_hu};
    else
      legal = r.funct3 inside {lsu_pkg::lsu_f3_b, lsu_pkg::lsu_f3_h, lsu_pkg::lsu_f3_w};
    if (r.op != lsu_pkg::lsu_op_none) begin
      if (!legal || !aligned) begin
        exp.fault = 1'b1;
      end else if (idx >= 10'd64) begin
        fail_run("stimulus address left the model window");
      end else if (r.op == lsu_pkg::lsu_op_store) begin
        case (r.funct3)
          lsu_pkg::lsu_f3_b: model_mem[idx[5:0]].b[off] = r.src2[7:0];
          lsu_pkg::lsu_f3_h: begin
            model_mem[idx[5:0]].b[off]        = r.src2[7:0];   // little endian
            model_mem[idx[5:0]].b[off + 2'd1] = r.src2[15:8];
          end
          default: model_mem[idx[5:0]] = r.src2;
        endcase
      end else begin
        bv = model_mem[idx[5:0]].b[off];
        hv = {model_mem[idx[5:0]].b[off + 2'd1], model_mem[idx[5:0]].b[off]};
        exp.rd_wen = 1'b1;
        case (r.funct3)
          lsu_pkg::lsu_f3_b:  exp.result = {{24{bv[7]}}, bv};
          lsu_pkg::lsu_f3_bu: exp.result = {24'd0, bv};
          lsu_pkg::lsu_f3_h:  exp.result = {{16{hv[15]}}, hv};
          lsu_pkg::lsu_f3_hu: exp.result = {16'd0, hv};
          default:            exp.result = model_mem[idx[5:0]];
        endcase
      end
    end
  endtask

  // drive one request for one cycle, response due two cycles later
  task automatic issue(input lsu_pkg::lsu_op_e op, input logic [2:0] f3,
                       input logic [31:0] src1, input logic [31:0] src2,
                       input logic [31:0] imm, input bit word_chk);
    lsu_pkg::lsu_req_t  r;
    lsu_pkg::lsu_resp_t exp;
    r.valid  = 1'b1;
    r.op     = op;
    r.funct3 = f3;
    r.src1   = src1;
    r.src2   = src2;
    r.imm    = imm;
    predict(r, exp);
    req = r;
    exp_q.push_back(exp);
    due_q.push_back(cycle + 2);
    name_q.push_back(cur_test);
    word_q.push_back(word_chk);
    @(posedge clk);
    #1;
    req = '0;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (resp.valid !== 1'b0) begin
      @(posedge clk);
      #1;
      n++;
      if (n > 10) fail_run("timeout: resp.valid stays high after reset");
    end
  endtask

  task automatic drain_queue();
    int n;
    n = 0;
    while (due_q.size() != 0) begin
      @(posedge clk);
      #1;
      n++;
      if (n > 20) fail_run("timeout: expected responses never arrived");
    end
  endtask

  // resp is combinational from stage 2, stable at the falling edge
  always @(negedge clk) begin : monitor
    lsu_pkg::lsu_resp_t none_exp;
    lsu_pkg::lsu_word_u got_word;
    lsu_pkg::lsu_word_u exp_word;
    none_exp = '0;
    if (rst_n) begin
      if (due_q.size() != 0 && due_q[0] == cycle) begin
        if (word_q[0]) begin
          got_word = resp.result;
          exp_word = exp_q[0].result;
          check_word(name_q[0], exp_word, got_word);
        end
        check_resp(name_q[0], exp_q[0], resp);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
        void'(name_q.pop_front());
        void'(word_q.pop_front());
      end else begin
        check_resp(cur_test, none_exp, resp);
      end
    end
  end

  initial begin : stimulus
    logic [31:0]       v;
    logic [31:0]       d;
    logic [31:0]       src1v;
    logic [31:0]       immv;
    logic [5:0]        widx;
    logic [1:0]        off;
    logic [2:0]        f3;
    logic [2:0]        kind;
    lsu_pkg::lsu_op_e  op;
    lfsr_state = 32'heed08f26;
    rst_n = 1'b0;
    req   = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    wait_reset_release();

    cur_test = "word_readback";
    for (int w = 0; w < 64; w++) begin
      rand_bits(32, d);
      make_addr(6'(w), 2'd0, 1'b0, src1v, immv);
      issue(lsu_pkg::lsu_op_store, lsu_pkg::lsu_f3_w, src1v, d, immv, 1'b0);
    end
    for (int w = 0; w < 64; w++) begin
      make_addr(6'(w), 2'd0, 1'b0, src1v, immv);
      issue(lsu_pkg::lsu_op_load, lsu_pkg::lsu_f3_w, src1v, 32'd0, immv, 1'b1);
    end
    drain_queue();

    cur_test = "subword_store";
    repeat (48) begin
      rand_bits(6, v);
      widx = v[5:0];
      rand_bits(3, v);
      f3  = v[2] ? lsu_pkg::lsu_f3_h : lsu_pkg::lsu_f3_b;
      off = v[2] ? {v[1], 1'b0} : v[1:0];
      rand_bits(32, d);
      make_addr(widx, off, 1'b0, src1v, immv);
      issue(lsu_pkg::lsu_op_store, f3, src1v, d, immv, 1'b0);
      make_addr(widx, 2'd0, 1'b0, src1v, immv);
      issue(lsu_pkg::lsu_op_load, lsu_pkg::lsu_f3_w, src1v, 32'd0, immv, 1'b1);
    end
    drain_queue();

    cur_test = "load_extend";
    repeat (64) begin
      rand_bits(6, v);
      widx = v[5:0];
      rand_bits(4, v);
      case (v[3:2])
        2'd0:    f3 = lsu_pkg::lsu_f3_b;
        2'd1:    f3 = lsu_pkg::lsu_f3_bu;
        2'd2:    f3 = lsu_pkg::lsu_f3_h;
        default: f3 = lsu_pkg::lsu_f3_hu;
      endcase
      off = v[3] ? {v[1], 1'b0} : v[1:0];   // halves stay even
      make_addr(widx, off, 1'b0, src1v, immv);
      issue(lsu_pkg::lsu_op_load, f3, src1v, 32'd0, immv, 1'b0);
    end
    drain_queue();

    cur_test = "fault";
    repeat (48) begin
      rand_bits(6, v);
      widx = v[5:0];
      rand_bits(3, v);
      kind = v[2:0];
      rand_bits(2, v);
      off = v[1:0];
      rand_bits(3, v);
      f3 = v[2:0];
      rand_bits(32, d);
      case (kind)
        3'd0: begin
          op = lsu_pkg::lsu_op_load;
          f3 = lsu_pkg::lsu_f3_h;
          off[0] = 1'b1;
        end
        3'd1: begin
          op = lsu_pkg::lsu_op_load;
          f3 = lsu_pkg::lsu_f3_w;
          if (off == 2'd0) off = 2'd2;
        end
        3'd2: begin
          op = lsu_pkg::lsu_op_store;
          f3 = lsu_pkg::lsu_f3_h;
          off[0] = 1'b1;
        end
        3'd3: begin
          op = lsu_pkg::lsu_op_store;
          f3 = lsu_pkg::lsu_f3_w;
          if (off == 2'd0) off = 2'd1;
        end
        3'd4: begin
          op = lsu_pkg::lsu_op_load;
          f3 = f3[0] ? 3'b011 : {2'b11, f3[1]};   // 011, 110 or 111
        end
        default: begin
          op = lsu_pkg::lsu_op_store;
          if (f3 < 3'd3) f3 = f3 + 3'd3;
        end
      endcase
      make_addr(widx, off, 1'b0, src1v, immv);
      issue(op, f3, src1v, d, immv, 1'b0);
      make_addr(widx, 2'd0, 1'b0, src1v, immv);
      issue(lsu_pkg::lsu_op_load, lsu_pkg::lsu_f3_w, src1v, 32'd0, immv, 1'b1);
    end
    drain_queue();

    cur_test = "back_to_back";
    repeat (200) begin
      rand_bits(6, v);
      widx = v[5:0];
      rand_bits(7, v);
      kind = {1'b0, v[6:5]};
      off  = v[4:3];
      f3   = v[2:0];
      rand_bits(32, d);
      make_addr(widx, off, 1'b0, src1v, immv);
      case (kind)
        3'd0: issue(lsu_pkg::lsu_op_none, f3, src1v, d, immv, 1'b0);
        3'd1: issue(lsu_pkg::lsu_op_load, f3, src1v, d, immv, 1'b0);
        3'd2: issue(lsu_pkg::lsu_op_store, f3, src1v, d, immv, 1'b0);
        default: begin
          // store, then a load of the same word in the very next cycle
          make_addr(widx, 2'd0, 1'b0, src1v, immv);
          issue(lsu_pkg::lsu_op_store, lsu_pkg::lsu_f3_w, src1v, d, immv, 1'b0);
          issue(lsu_pkg::lsu_op_load, lsu_pkg::lsu_f3_w, src1v, 32'd0, immv, 1'b1);
        end
      endcase
    end
    drain_queue();

    cur_test = "address_wrap";
    repeat (32) begin
      rand_bits(6, v);
      widx = v[5:0];
      rand_bits(2, v);
      off = v[1:0];
      rand_bits(32, d);
      make_addr(widx, 2'd0, 1'b1, src1v, immv);
      issue(lsu_pkg::lsu_op_store, lsu_pkg::lsu_f3_w, src1v, d, immv, 1'b0);
      make_addr(widx, 2'd0, 1'b0, src1v, immv);
      issue(lsu_pkg::lsu_op_load, lsu_pkg::lsu_f3_w, src1v, 32'd0, immv, 1'b1);
      make_addr(widx, off, 1'b1, src1v, immv);
      issue(lsu_pkg::lsu_op_load, lsu_pkg::lsu_f3_bu, src1v, 32'd0, immv, 1'b0);
    end
    drain_queue();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hw/lsu_pkg.sv
hw/lsu_agu.sv
hw/lsu_data_ram.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
tests/lsu_assertions.sv
tests/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the LSU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=lsu_sim

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module lsu_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN" \
  -f vlog.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"

if grep -q "CHECKS FAILED" "$LOG_FILE"; then
  echo "simulation reported a failure, see $LOG_FILE"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "simulation finished cleanly"
exit 0
